//--- build.f
+incdir+testbench
verilog/router_stats_pkg.sv
verilog/port_snapshot_bank.sv
verilog/stats_csr_regfile.sv
verilog/router_stats_top.sv
testbench/router_stats_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the router statistics testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module router_stats_tb -f build.f -o router_stats_sim &&
./obj_dir/router_stats_sim | tee /dev/stderr | grep -qx '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- testbench/router_stats_patterns.txt
# W addr data | R addr rdata err | S port pkt byte err | D port pulses
# All fields hex, port p bank starts at word 5 + 4p
R 00 0100000a 0
R 01 00000015 0
R 03 0000000f 0
W 02 00000005
R 03 00000005 0
W 00 12345678
W 01 ffffffff
R 00 0100000a 0
R 01 00000015 0
W 02 0000000f
S 0 00000011 00000400 00000001
S 1 00000022 00000800 00000002
S 2 00000033 00000c00 00000003
S 3 00000044 00001000 00000004
W 04 00000000
W 04 0000000f
R 05 00000011 0
R 0a 00000800 0
R 13 00000004 0
S 0 00000111 00004400 00000010
S 1 00000222 00008800 00000020
S 2 00000333 0000cc00 00000030
S 3 00000444 00011000 00000040
W 04 00000000
W 04 00000005
R 05 00000111 0
R 09 00000022 0
R 0e 0000cc00 0
R 11 00000044 0
D 0 3
D 1 1
D 2 2
W 04 00000000
W 04 0000000f
R 08 00000003 0
R 0c 00000001 0
R 10 00000002 0
R 14 00000000 0
W 04 00000000
W 04 0000000f
R 08 00000000 0
R 0c 00000000 0
R 15 00000000 1
W 15 deadbeef
R ff 00000000 1
W 80 00000000
R 02 0000000f 0
R 04 0000000f 0

//--- testbench/router_stats_checks.svh
//////////////////////////////////////////////////
// Compare tasks and timed response wait
//////////////////////////////////////////////////

    // Compares valid, err and rdata as one word
    task automatic check_rsp(input string name,
                             input router_stats_pkg::bus_rsp_t got,
                             input router_stats_pkg::bus_rsp_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_enable(input logic [NUM_PORTS-1:0] got,
                                input logic [NUM_PORTS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error port_enable: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // Response wait
    //////////////////////////////////////////////////

    // Polls valid at the falling edge and counts the latency in cycles
    task automatic wait_rsp(output int latency, output router_stats_pkg::bus_rsp_t rsp);
        latency = 1;
        @(negedge core_clk_ifc);
        while (!bus_rsp.valid) begin
            if (latency >= RSP_TIMEOUT) begin
                stop_on_error("timed out waiting for bus_rsp.valid");
            end
            @(negedge core_clk_ifc);
            latency++;
        end
        rsp = bus_rsp;
    endtask

//--- testbench/router_stats_tb.sv
//////////////////////////////////////////////////
// Testbench for the router statistics block
//////////////////////////////////////////////////

`timescale 1ns/100ps

module router_stats_tb;

    localparam int    NUM_PORTS    = 4;
    localparam int    NUM_REGS     = 5 + 4 * NUM_PORTS;
    localparam int    RSP_TIMEOUT  = 20;
    localparam int    MAX_OPS      = 1000;
    localparam string PATTERN_FILE = "testbench/router_stats_patterns.txt";

    logic                          core_clk_ifc;
    logic                          peripheral_sresetn_core;
    router_stats_pkg::bus_req_t    bus_req;
    router_stats_pkg::bus_rsp_t    bus_rsp;
    router_stats_pkg::port_stats_t port_stats [NUM_PORTS];
    logic [NUM_PORTS-1:0]          buf_full_drop;
    logic [NUM_PORTS-1:0]          port_enable;

    // Expected port_enable from writes to the control register
    logic [NUM_PORTS-1:0]          enable_model;
    int unsigned                   lcg_state;

    router_stats_top #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) i_router_stats_top (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bus_req                 ( bus_req                 ),
        .bus_rsp                 ( bus_rsp                 ),
        .port_stats              ( port_stats              ),
        .buf_full_drop           ( buf_full_drop           ),
        .port_enable             ( port_enable             )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever begin
            #20 core_clk_ifc = ~core_clk_ifc;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    `include "router_stats_checks.svh"

    //////////////////////////////////////////////////
    // Bus and port stimulus
    //////////////////////////////////////////////////

    // One strobe and a response exactly one cycle later
    task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output router_stats_pkg::bus_rsp_t rsp);
        int latency;
        @(posedge core_clk_ifc);
        bus_req <= {wr, ~wr, addr, data};
        @(posedge core_clk_ifc);
        bus_req <= '0;
        wait_rsp(latency, rsp);
        if (latency != 1) begin
            stop_on_error($sformatf("response came %0d cycles after the request", latency));
        end
        @(negedge core_clk_ifc);
        if (bus_rsp.valid) begin
            stop_on_error("bus_rsp.valid stayed high for more than one cycle");
        end
    endtask

    task automatic do_write(input logic [7:0] addr, input logic [31:0] data);
        router_stats_pkg::bus_rsp_t rsp;
        router_stats_pkg::bus_rsp_t exp;
        bus_access(1'b1, addr, data, rsp);
        exp = {1'b1, (addr >= NUM_REGS), 32'h0};
        check_rsp("bus_rsp", rsp, exp);
        if (addr == 8'(router_stats_pkg::ADDR_PORT_ENABLE_CON)) begin
            enable_model = data[NUM_PORTS-1:0];
        end
        check_enable(port_enable, enable_model);
        // Snapshot registers settle three cycles after the write
        if (addr == 8'(router_stats_pkg::ADDR_COUNTER_CON)) begin
            repeat (4) @(posedge core_clk_ifc);
        end
    endtask

    task automatic do_read(input logic [7:0] addr, input logic [31:0] data, input logic err);
        router_stats_pkg::bus_rsp_t rsp;
        router_stats_pkg::bus_rsp_t exp;
        bus_access(1'b0, addr, 32'h0, rsp);
        exp = {1'b1, err, data};
        check_rsp("bus_rsp", rsp, exp);
        check_enable(port_enable, enable_model);
    endtask

    // Separated pulses of one cycle high and one cycle low
    task automatic pulse_drops(input int port, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge core_clk_ifc);
            buf_full_drop[port] <= 1'b1;
            @(posedge core_clk_ifc);
            buf_full_drop[port] <= 1'b0;
        end
        @(posedge core_clk_ifc);
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic check_fields(input int code, input int count);
        if (code != count) begin
            stop_on_error("malformed line in the pattern file");
        end
    endtask

    //////////////////////////////////////////////////
    // Pattern file sequencer
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        int          code;
        int          ops;
        logic [7:0]  op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_c;
        logic [31:0] f_d;
        peripheral_sresetn_core = 1'b0;
        bus_req                 = '0;
        buf_full_drop           = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_stats[p] = '0;
        end
        enable_model = '1;
        lcg_state    = 32'd93828;
        ops          = 0;
        repeat (3) @(posedge core_clk_ifc);
        peripheral_sresetn_core <= 1'b1;
        @(negedge core_clk_ifc);
        check_rsp("bus_rsp", bus_rsp, '0);
        check_enable(port_enable, enable_model);
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            stop_on_error("cannot open the pattern file");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                break;
            end
            if (op == "#") begin
                skip_line(fd);
                continue;
            end
            case (op)
                "W": begin
                    code = $fscanf(fd, "%h %h", f_a, f_b);
                    check_fields(code, 2);
                    do_write(f_a[7:0], f_b);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                    check_fields(code, 3);
                    do_read(f_a[7:0], f_b, f_c[0]);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h %h %h", f_a, f_b, f_c, f_d);
                    check_fields(code, 4);
                    @(posedge core_clk_ifc);
                    port_stats[f_a] <= {f_b, f_c, f_d};
                end
                "D": begin
                    code = $fscanf(fd, "%h %h", f_a, f_b);
                    check_fields(code, 2);
                    pulse_drops(f_a, f_b);
                end
                default: begin
                    stop_on_error($sformatf("unknown operation %c in the pattern file", op));
                end
            endcase
            ops++;
            if (ops > MAX_OPS) begin
                stop_on_error("pattern file holds too many operations");
            end
            // Idle gap of 0 to 3 cycles
            repeat ((lcg_next() >> 16) % 4) @(posedge core_clk_ifc);
        end
        $fclose(fd);
        if (ops == 0) begin
            stop_on_error("no operations read from the pattern file");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- verilog/router_stats_top.sv
//////////////////////////////////////////////////
// Router port statistics block, top level
//////////////////////////////////////////////////

`timescale 1ns/100ps

module router_stats_top #(
    parameter int NUM_PORTS = 4
) (
    input  logic                          core_clk_ifc,
    input  logic                          peripheral_sresetn_core,

    // Register bus
    input  router_stats_pkg::bus_req_t    bus_req,
    output router_stats_pkg::bus_rsp_t    bus_rsp,

    // Per-port statistics sources
    input  router_stats_pkg::port_stats_t port_stats [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]          buf_full_drop,

    // Port control
    output logic [NUM_PORTS-1:0]          port_enable
);

    localparam int NUM_SNAP = NUM_PORTS * router_stats_pkg::REGS_PER_PORT;

    //////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////

    // Snapshot trigger, one bit per port
    logic [NUM_PORTS-1:0] sample_req;

    // Flattened snapshot words, REGS_PER_PORT per port
    logic [router_stats_pkg::DATA_W-1:0] snap_regs [NUM_SNAP];

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    stats_csr_regfile #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) i_stats_csr_regfile (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bus_req                 ( bus_req                 ),
        .snap_regs               ( snap_regs               ),
        .bus_rsp                 ( bus_rsp                 ),
        .port_enable             ( port_enable             ),
        .sample_req              ( sample_req              )
    );

    //////////////////////////////////////////////////
    // Snapshot bank
    //////////////////////////////////////////////////

    // Steered by sample_req from the register file
    port_snapshot_bank #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) i_port_snapshot_bank (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_req              ( sample_req              ),
        .port_stats              ( port_stats              ),
        .buf_full_drop           ( buf_full_drop           ),
        .snap_regs               ( snap_regs               )
    );

endmodule

//--- verilog/stats_csr_regfile.sv
//////////////////////////////////////////////////
// Address decode, control/status registers,
// readback mux and bus response generation
//////////////////////////////////////////////////

`timescale 1ns/100ps

module stats_csr_regfile #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                core_clk_ifc,
    input  logic                                peripheral_sresetn_core,

    input  router_stats_pkg::bus_req_t          bus_req,
    input  logic [router_stats_pkg::DATA_W-1:0] snap_regs
                                                [NUM_PORTS*router_stats_pkg::REGS_PER_PORT],

    output router_stats_pkg::bus_rsp_t          bus_rsp,
    output logic [NUM_PORTS-1:0]                port_enable,
    output logic [NUM_PORTS-1:0]                sample_req
);

    localparam int DATA_W     = router_stats_pkg::DATA_W;
    localparam int ADDR_W     = router_stats_pkg::ADDR_W;
    localparam int NUM_SNAP   = NUM_PORTS * router_stats_pkg::REGS_PER_PORT;
    localparam int SNAP_BASE  = int'(router_stats_pkg::ADDR_COUNTERS_START);
    localparam int NUM_REGS   = SNAP_BASE + NUM_SNAP;
    localparam int SNAP_IDX_W = $clog2(NUM_SNAP);

    //////////////////////////////////////////////////
    // Registers and decode signals
    //////////////////////////////////////////////////

    logic [NUM_PORTS-1:0]        port_en_con;
    logic [NUM_PORTS-1:0]        port_en_stat;
    logic [DATA_W-1:0]           counter_con;

    router_stats_pkg::reg_addr_e req_addr;
    logic                        req_any;
    logic                        in_range;
    logic                        wr_port_en;
    logic                        wr_counter_con;
    logic [SNAP_IDX_W-1:0]       snap_idx;
    logic [DATA_W-1:0]           rd_data;

    assign req_addr = router_stats_pkg::reg_addr_e'(bus_req.addr);
    assign req_any  = bus_req.wr | bus_req.rd;

    // Anything past the last snapshot word is an error
    assign in_range = (bus_req.addr < ADDR_W'(NUM_REGS));

    // Only the two control registers take writes
    assign wr_port_en     = bus_req.wr && (req_addr == router_stats_pkg::ADDR_PORT_ENABLE_CON);
    assign wr_counter_con = bus_req.wr && (req_addr == router_stats_pkg::ADDR_COUNTER_CON);

    // Word index into the flattened snapshot array
    assign snap_idx = SNAP_IDX_W'(bus_req.addr - ADDR_W'(SNAP_BASE));

    //////////////////////////////////////////////////
    // Control and status registers
    //////////////////////////////////////////////////

    // All ports come out of reset enabled
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            port_en_con <= '1;
        end else if (wr_port_en) begin
            port_en_con <= bus_req.wdata[NUM_PORTS-1:0];
        end
    end

    // Status trails the control register by one cycle
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            port_en_stat <= '1;
        end else begin
            port_en_stat <= port_en_con;
        end
    end

    assign port_enable = port_en_con;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            counter_con <= '0;
        end else if (wr_counter_con) begin
            counter_con <= bus_req.wdata;
        end
    end

    // One register stage between the control word and the bank
    // Rising bits are detected in the bank
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_req <= '0;
        end else begin
            sample_req <= counter_con[NUM_PORTS-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Readback mux
    //////////////////////////////////////////////////

    always_comb begin
        rd_data = '0;
        if (in_range) begin
            case (req_addr)
                router_stats_pkg::ADDR_VERSION_ID: begin
                    rd_data = router_stats_pkg::VERSION_ID;
                end
                router_stats_pkg::ADDR_NUM_REGS: begin
                    rd_data = DATA_W'(NUM_REGS);
                end
                router_stats_pkg::ADDR_PORT_ENABLE_CON: begin
                    rd_data = DATA_W'(port_en_con);
                end
                router_stats_pkg::ADDR_PORT_ENABLE_STAT: begin
                    rd_data = DATA_W'(port_en_stat);
                end
                router_stats_pkg::ADDR_COUNTER_CON: begin
                    rd_data = counter_con;
                end
                // Port banks from ADDR_COUNTERS_START upward
                default: begin
                    rd_data = snap_regs[snap_idx];
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    // One-cycle valid pulse the cycle after any request
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            bus_rsp <= '0;
        end else begin
            bus_rsp.valid <= req_any;
            bus_rsp.err   <= req_any && !in_range;
            // Writes return zero data
            bus_rsp.rdata <= bus_req.rd ? rd_data : '0;
        end
    end

endmodule

//--- verilog/port_snapshot_bank.sv
//////////////////////////////////////////////////
// Per-port sample edge detect, drop counters
// and snapshot registers
//////////////////////////////////////////////////

`timescale 1ns/100ps

module port_snapshot_bank #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                core_clk_ifc,
    input  logic                                peripheral_sresetn_core,

    input  logic [NUM_PORTS-1:0]                sample_req,
    input  router_stats_pkg::port_stats_t       port_stats [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]                buf_full_drop,

    output logic [router_stats_pkg::DATA_W-1:0] snap_regs
                                                [NUM_PORTS*router_stats_pkg::REGS_PER_PORT]
);

    localparam int DATA_W        = router_stats_pkg::DATA_W;
    localparam int CNTR_W        = router_stats_pkg::CNTR_W;
    localparam int REGS_PER_PORT = router_stats_pkg::REGS_PER_PORT;

    //////////////////////////////////////////////////
    // Edge detection
    //////////////////////////////////////////////////

    logic [NUM_PORTS-1:0] sample_req_d;
    logic [NUM_PORTS-1:0] buf_full_drop_d;
    logic [NUM_PORTS-1:0] sample_rise;
    logic [NUM_PORTS-1:0] drop_rise;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_req_d    <= '0;
            buf_full_drop_d <= '0;
        end else begin
            sample_req_d    <= sample_req;
            buf_full_drop_d <= buf_full_drop;
        end
    end

    // A held request or a held drop level counts once
    assign sample_rise = sample_req & ~sample_req_d;
    assign drop_rise   = buf_full_drop & ~buf_full_drop_d;

    //////////////////////////////////////////////////
    // Per-port counters and snapshots
    //////////////////////////////////////////////////

    genvar p;
    generate
        for (p = 0; p < NUM_PORTS; p++) begin : gen_port
            router_stats_pkg::port_stats_t snap_stats;
            logic [CNTR_W-1:0]             drop_cnt;
            logic [CNTR_W-1:0]             snap_drop;

            // Drop edges since the last snapshot
            always_ff @(posedge core_clk_ifc) begin
                if (!peripheral_sresetn_core) begin
                    drop_cnt <= '0;
                end else if (sample_rise[p]) begin
                    // Edge in the snapshot cycle opens the next interval
                    drop_cnt <= drop_rise[p] ? CNTR_W'(1) : '0;
                end else if (drop_rise[p]) begin
                    drop_cnt <= drop_cnt + 1'b1;
                end
            end

            // Capture the outside counters and the interval drop count
            always_ff @(posedge core_clk_ifc) begin
                if (!peripheral_sresetn_core) begin
                    snap_stats <= '0;
                    snap_drop  <= '0;
                end else if (sample_rise[p]) begin
                    snap_stats <= port_stats[p];
                    snap_drop  <= drop_cnt;
                end
            end

            // Bank layout follows the SNAP_* offsets
            assign snap_regs[p*REGS_PER_PORT + router_stats_pkg::SNAP_PKT] =
                DATA_W'(snap_stats.pkt_cnt);
            assign snap_regs[p*REGS_PER_PORT + router_stats_pkg::SNAP_BYTE] =
                DATA_W'(snap_stats.byte_cnt);
            assign snap_regs[p*REGS_PER_PORT + router_stats_pkg::SNAP_ERR] =
                DATA_W'(snap_stats.err_cnt);
            assign snap_regs[p*REGS_PER_PORT + router_stats_pkg::SNAP_DROP] =
                DATA_W'(snap_drop);
        end
    endgenerate

endmodule

//--- verilog/router_stats_pkg.sv
//////////////////////////////////////////////////
// Widths, register map, bus request/response and
// per-port statistics types for the stats block
//////////////////////////////////////////////////

package router_stats_pkg;

    //////////////////////////////////////////////////
    // Widths and constants
    //////////////////////////////////////////////////

    localparam int DATA_W        = 32;
    localparam int ADDR_W        = 8;
    localparam int CNTR_W        = 32;
    localparam int REGS_PER_PORT = 4;

    // Version 1.0 in the upper half, block ID in the lower half
    localparam logic [15:0] MODULE_VERSION = 16'h0100;
    localparam logic [15:0] MODULE_ID      = 16'd10;
    localparam logic [DATA_W-1:0] VERSION_ID = {MODULE_VERSION, MODULE_ID};

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    // Fixed word addresses with the port banks from ADDR_COUNTERS_START upward
    typedef enum logic [ADDR_W-1:0] {
        ADDR_VERSION_ID       = 8'd0,
        ADDR_NUM_REGS         = 8'd1,
        ADDR_PORT_ENABLE_CON  = 8'd2,
        ADDR_PORT_ENABLE_STAT = 8'd3,
        ADDR_COUNTER_CON      = 8'd4,
        ADDR_COUNTERS_START   = 8'd5
    } reg_addr_e;

    // Offsets inside one port bank
    localparam int SNAP_PKT  = 0;
    localparam int SNAP_BYTE = 1;
    localparam int SNAP_ERR  = 2;
    localparam int SNAP_DROP = 3;

    //////////////////////////////////////////////////
    // Bus and statistics structs
    //////////////////////////////////////////////////

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    // Levels from the outside profile counters of one port
    typedef struct packed {
        logic [CNTR_W-1:0] pkt_cnt;
        logic [CNTR_W-1:0] byte_cnt;
        logic [CNTR_W-1:0] err_cnt;
    } port_stats_t;

endpackage
